// ==== spin_pkg.sv ====
package spin_pkg;

    // Width of one spin vector
    localparam int DATASPIN = 32;

    // Number of entries held by the spin FIFO
    localparam int SPIN_DEPTH = 4;

    // Pointer width, at least one bit even for a single entry
    localparam int ADDR_DEPTH = (SPIN_DEPTH > 1) ? $clog2(SPIN_DEPTH) : 1;

    // Width of the programmed iteration count
    localparam int ITER_W = 16;

    // One spin vector as it moves through the buffer
    typedef logic [DATASPIN-1:0] spin_t;

    // Read and write pointer into the FIFO storage
    typedef logic [ADDR_DEPTH-1:0] ptr_t;

    // Occupancy count
    // One extra bit so a full FIFO reads as SPIN_DEPTH
    typedef logic [ADDR_DEPTH:0] usage_t;

    // Iteration counter value
    typedef logic [ITER_W-1:0] iter_t;

    // Last valid pointer before wrap
    localparam ptr_t LAST_PTR = ptr_t'(SPIN_DEPTH - 1);

    // Occupancy at which the FIFO reports full
    localparam usage_t USAGE_FULL = usage_t'(SPIN_DEPTH);

    // All-zero vector stored by a push-none
    localparam spin_t SPIN_ZERO = '0;

endpackage

// ==== spin_stream_if.sv ====
`timescale 1ns/1ps

interface spin_stream_if;
    import spin_pkg::*;

    // Source has a word on data
    logic  valid;

    // Spin vector payload
    spin_t data;

    // Store a zero vector instead of data
    // Only meaningful on the push stream
    logic  none;

    // Sink can take the word this cycle
    logic  ready;

    // Side that offers words
    modport source (
        output valid,
        output data,
        output none,
        input  ready
    );

    // Side that takes words
    modport sink (
        input  valid,
        input  data,
        input  none,
        output ready
    );

endinterface

// ==== spin_fifo.sv ====
`timescale 1ns/1ps

module spin_fifo (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             flush_i,
    input  logic             push_i,
    input  logic             push_none_i,
    input  spin_pkg::spin_t  data_i,
    input  logic             pop_i,
    output spin_pkg::spin_t  data_o,
    output logic             full_o,
    output logic             empty_o,
    output spin_pkg::usage_t usage_o
);
    import spin_pkg::*;

    // Storage array
    spin_t  mem [SPIN_DEPTH];

    // Circular pointers
    ptr_t   wr_ptr;
    ptr_t   rd_ptr;

    // Occupancy counter
    usage_t count;

    // Qualified push and pop for this cycle
    logic   do_push;
    logic   do_pop;

    // Word actually written on a push
    spin_t  wr_word;

    // Advance a pointer with wrap at the last entry
    function automatic ptr_t next_ptr(input ptr_t ptr);
        ptr_t nxt;
        if (ptr == LAST_PTR) begin
            nxt = '0;
        end else begin
            nxt = ptr + ptr_t'(1);
        end
        return nxt;
    endfunction

    // Status straight from the counter
    assign full_o  = (count == USAGE_FULL);
    assign empty_o = (count == '0);
    assign usage_o = count;

    // Flush drops any push in the same cycle
    assign do_push = push_i & ~full_o & ~flush_i;
    assign do_pop  = pop_i & ~empty_o & ~flush_i;

    // Push-none replaces the payload with zeros
    assign wr_word = push_none_i ? SPIN_ZERO : data_i;

    // Head of queue
    // Written words show up here one cycle later, no fall-through
    assign data_o = mem[rd_ptr];

    // Payload storage
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    // Write pointer
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            wr_ptr <= '0;
        end else if (do_push) begin
            wr_ptr <= next_ptr(wr_ptr);
        end
    end

    // Read pointer
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            rd_ptr <= '0;
        end else if (do_pop) begin
            rd_ptr <= next_ptr(rd_ptr);
        end
    end

    // Occupancy
    // Push and pop together leave it unchanged
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            count <= '0;
        end else begin
            case ({do_push, do_pop})
                2'b10: begin
                    count <= count + usage_t'(1);
                end
                2'b01: begin
                    count <= count - usage_t'(1);
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

// ==== spin_maintainer.sv ====
`timescale 1ns/1ps

module spin_maintainer (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             en_i,
    input  logic             flush_i,
    input  logic             cmpt_en_i,
    input  logic             host_readout_i,
    input  logic             icon_finish_i,
    spin_stream_if.sink      push,
    spin_stream_if.source    pop,
    output logic             cmpt_start_o,
    output logic             pop_fire_o,
    output logic             cmpt_busy_o,
    output spin_pkg::usage_t usage_o
);

    // FIFO status
    logic fifo_full;
    logic fifo_empty;

    // Handshake outcomes
    logic fifo_push;
    logic fifo_pop;

    // Completion status conditions
    logic cmpt_stop;
    logic cmpt_busy_q;

    // Spin storage, head word goes straight to the pop stream
    spin_fifo u_spin_fifo (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .push_i      (fifo_push),
        .push_none_i (push.none),
        .data_i      (push.data),
        .pop_i       (fifo_pop),
        .data_o      (pop.data),
        .full_o      (fifo_full),
        .empty_o     (fifo_empty),
        .usage_o     (usage_o)
    );

    // Push side accepts while enabled and room left
    assign push.ready = ~fifo_full & en_i;
    assign fifo_push  = push.valid & push.ready;

    // Pops open for host readout or a running computation
    // A finished computation closes the gate
    assign pop.valid  = en_i & ~fifo_empty &
                        (host_readout_i | (cmpt_busy_q & ~icon_finish_i));
    assign fifo_pop   = pop.valid & pop.ready;

    // Pop stream never carries a none request
    assign pop.none   = 1'b0;

    // Arm request seen by the tracker
    assign cmpt_start_o = cmpt_en_i & en_i;
    assign pop_fire_o   = fifo_pop;

    // Computation over once finished and refilled
    assign cmpt_stop = icon_finish_i & fifo_full;

    // Completion busy register
    // Clearing wins over arming
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i || cmpt_stop) begin
            cmpt_busy_q <= 1'b0;
        end else if (cmpt_start_o) begin
            cmpt_busy_q <= 1'b1;
        end
    end

    assign cmpt_busy_o = cmpt_busy_q;

endmodule

// ==== icon_tracker.sv ====
`timescale 1ns/1ps

module icon_tracker (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            flush_i,
    input  logic            cmpt_start_i,
    input  logic            pop_fire_i,
    input  logic            busy_i,
    input  spin_pkg::iter_t num_iter_i,
    output logic            icon_finish_o,
    output spin_pkg::iter_t iter_count_o
);
    import spin_pkg::*;

    // Counter state
    iter_t count_q;
    logic  finish_q;

    // Counter step
    iter_t count_next;

    // Pop counted this cycle
    logic  count_en;

    // This pop reaches the programmed count
    logic  hit;

    // Only pops inside an unfinished computation count
    assign count_en   = pop_fire_i & busy_i & ~finish_q;
    assign count_next = count_q + iter_t'(1);
    assign hit        = count_en & (count_next == num_iter_i);

    // Iteration counter
    // Restarts on every new computation
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i || cmpt_start_i) begin
            count_q <= '0;
        end else if (count_en) begin
            count_q <= count_next;
        end
    end

    // Finish flag
    // Rises the cycle after the last counted pop, then holds
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i || cmpt_start_i) begin
            finish_q <= 1'b0;
        end else if (hit) begin
            finish_q <= 1'b1;
        end
    end

    assign icon_finish_o = finish_q;
    assign iter_count_o  = count_q;

endmodule

// ==== spin_buffer_top.sv ====
`timescale 1ns/1ps

module spin_buffer_top (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             en_i,
    input  logic             flush_i,
    input  logic             cmpt_en_i,
    input  logic             host_readout_i,
    input  spin_pkg::iter_t  num_iter_i,

    // Host push stream
    input  logic             push_valid_i,
    input  spin_pkg::spin_t  push_data_i,
    input  logic             push_none_i,
    output logic             push_ready_o,

    // Core pop stream
    output logic             pop_valid_o,
    output spin_pkg::spin_t  pop_data_o,
    input  logic             pop_ready_i,

    // Status
    output logic             cmpt_busy_o,
    output logic             icon_finish_o,
    output spin_pkg::iter_t  iter_count_o,
    output spin_pkg::usage_t usage_o
);

    // Stream bundles between the pins and the maintainer
    spin_stream_if push_if ();
    spin_stream_if pop_if ();

    // Maintainer to tracker links
    logic cmpt_start;
    logic pop_fire;
    logic icon_finish;

    // Push pins into the bundle
    assign push_if.valid = push_valid_i;
    assign push_if.data  = push_data_i;
    assign push_if.none  = push_none_i;
    assign push_ready_o  = push_if.ready;

    // Pop bundle out to the pins
    assign pop_valid_o  = pop_if.valid;
    assign pop_data_o   = pop_if.data;
    assign pop_if.ready = pop_ready_i;

    // FIFO wrapper with push and pop gating
    spin_maintainer u_spin_maintainer (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .en_i           (en_i),
        .flush_i        (flush_i),
        .cmpt_en_i      (cmpt_en_i),
        .host_readout_i (host_readout_i),
        .icon_finish_i  (icon_finish),
        .push           (push_if.sink),
        .pop            (pop_if.source),
        .cmpt_start_o   (cmpt_start),
        .pop_fire_o     (pop_fire),
        .cmpt_busy_o    (cmpt_busy_o),
        .usage_o        (usage_o)
    );

    // Iteration counter for the running computation
    icon_tracker u_icon_tracker (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .flush_i       (flush_i),
        .cmpt_start_i  (cmpt_start),
        .pop_fire_i    (pop_fire),
        .busy_i        (cmpt_busy_o),
        .num_iter_i    (num_iter_i),
        .icon_finish_o (icon_finish),
        .iter_count_o  (iter_count_o)
    );

    assign icon_finish_o = icon_finish;

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk_o
);

    // Free-running clock, first rising edge after half a period
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk_o = ~clk_o;
        end
    end

endmodule

// ==== tb_spin_buffer.sv ====
`timescale 1ns/1ps

module tb_spin_buffer;
    import spin_pkg::*;

    localparam int   CLK_PERIOD   = 100;
    localparam int   RST_CYCLES   = 8;
    localparam int   DRIVE_DELAY  = 10;
    localparam int   SAMPLE_DELAY = 70;
    localparam int   MAX_STEPS    = 96;
    localparam logic HI           = 1'b1;
    localparam logic LO           = 1'b0;

    // One table row with stimulus first and expected response after
    typedef struct packed {
        logic  en;
        logic  flush;
        logic  cmpt_en;
        logic  host;
        iter_t num_iter;
        logic  push_valid;
        spin_t push_data;
        logic  push_none;
        logic  pop_ready;
        logic  exp_push_ready;
        logic  exp_pop_valid;
        spin_t exp_pop_data;
        usage_t exp_usage;
        logic  exp_busy;
        logic  exp_finish;
        iter_t exp_iter;
    } step_t;

    // DUT pins
    logic   clk_i;
    logic   rst_i;
    logic   en_i;
    logic   flush_i;
    logic   cmpt_en_i;
    logic   host_readout_i;
    iter_t  num_iter_i;
    logic   push_valid_i;
    spin_t  push_data_i;
    logic   push_none_i;
    logic   push_ready_o;
    logic   pop_valid_o;
    spin_t  pop_data_o;
    logic   pop_ready_i;
    logic   cmpt_busy_o;
    logic   icon_finish_o;
    iter_t  iter_count_o;
    usage_t usage_o;

    // Step table
    step_t  steps [MAX_STEPS];
    string  step_name [MAX_STEPS];
    int     n_steps;
    logic   table_built;

    // Reference model state updated once per clock edge
    spin_t  model_q [$];
    logic   model_busy;
    logic   model_finish;
    iter_t  model_count;

    // Host side hold of an offered word not yet taken
    logic   push_pending;
    spin_t  held_data;
    logic [31:0] lcg_state;

    tb_clk_gen #(.PERIOD_NS(CLK_PERIOD)) u_clk_gen (.clk_o(clk_i));

    spin_buffer_top UUT (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .en_i           (en_i),
        .flush_i        (flush_i),
        .cmpt_en_i      (cmpt_en_i),
        .host_readout_i (host_readout_i),
        .num_iter_i     (num_iter_i),
        .push_valid_i   (push_valid_i),
        .push_data_i    (push_data_i),
        .push_none_i    (push_none_i),
        .push_ready_o   (push_ready_o),
        .pop_valid_o    (pop_valid_o),
        .pop_data_o     (pop_data_o),
        .pop_ready_i    (pop_ready_i),
        .cmpt_busy_o    (cmpt_busy_o),
        .icon_finish_o  (icon_finish_o),
        .iter_count_o   (iter_count_o),
        .usage_o        (usage_o)
    );

    // Numerical Recipes LCG constants
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Run stopped after a failure");
    endtask

    task automatic check_spin(input string test, input string field,
                              input spin_t exp, input spin_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: %s expected %h, got %h", test, field, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_usage(input string test, input usage_t exp, input usage_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: usage expected %0d, got %0d", test, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input string test, input string field,
                             input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s: %s expected %b, got %b", test, field, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_iter(input string test, input iter_t exp, input iter_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: iter_count expected %0d, got %0d", test, exp, act);
            stop_with_failure();
        end
    endtask

    // Append one step, derive its expected outputs, then clock the model
    task automatic add_step(input string name, input logic en, input logic flush,
                            input logic cmpt_en, input logic host, input iter_t num_iter,
                            input logic push_valid, input logic push_none,
                            input logic pop_ready);
        step_t s;
        logic  full_now;
        logic  take_push;
        logic  take_pop;
        logic  start;
        logic  count_en;
        logic  hit;
        spin_t word;
        s = '0;
        s.en         = en;
        s.flush      = flush;
        s.cmpt_en    = cmpt_en;
        s.host       = host;
        s.num_iter   = num_iter;
        s.push_valid = push_valid;
        s.push_none  = push_none;
        s.pop_ready  = pop_ready;
        // Offered word is held until taken
        if (push_valid && push_pending) begin
            s.push_data = held_data;
        end else begin
            lcg_state   = lcg_next(lcg_state);
            s.push_data = spin_t'(lcg_state);
        end
        // Combinational outputs from state before the edge
        full_now         = (model_q.size() == SPIN_DEPTH);
        s.exp_push_ready = en && !full_now;
        s.exp_pop_valid  = en && (model_q.size() != 0) &&
                           (host || (model_busy && !model_finish));
        s.exp_pop_data   = s.exp_pop_valid ? model_q[0] : SPIN_ZERO;
        s.exp_usage      = usage_t'(model_q.size());
        s.exp_busy       = model_busy;
        s.exp_finish     = model_finish;
        s.exp_iter       = model_count;
        // Edge
        take_push = push_valid && s.exp_push_ready && !flush;
        take_pop  = s.exp_pop_valid && pop_ready && !flush;
        start     = cmpt_en && en;
        count_en  = s.exp_pop_valid && pop_ready && model_busy && !model_finish;
        hit       = count_en && (model_count + iter_t'(1) == num_iter);
        word      = push_none ? SPIN_ZERO : s.push_data;
        if (flush || (model_finish && full_now)) begin
            model_busy = LO;
        end else if (start) begin
            model_busy = HI;
        end
        if (flush || start) begin
            model_count  = '0;
            model_finish = LO;
        end else begin
            if (count_en) begin
                model_count = model_count + iter_t'(1);
            end
            if (hit) begin
                model_finish = HI;
            end
        end
        if (flush) begin
            model_q.delete();
        end else begin
            if (take_pop) begin
                void'(model_q.pop_front());
            end
            if (take_push) begin
                model_q.push_back(word);
            end
        end
        push_pending         = push_valid && !s.exp_push_ready;
        held_data            = s.push_data;
        step_name[n_steps]   = name;
        steps[n_steps]       = s;
        n_steps              = n_steps + 1;
    endtask

    task automatic build_table();
        n_steps      = 0;
        model_busy   = LO;
        model_finish = LO;
        model_count  = '0;
        push_pending = LO;
        held_data    = SPIN_ZERO;
        lcg_state    = 32'h733d_023b;
        model_q.delete();
        // Disabled right after reset
        add_step("disabled", LO, LO, LO, LO, 16'd0, LO, LO, LO);
        // Host readout keeps order and usage tracks push and pop
        repeat (2) add_step("readout_push", HI, LO, LO, HI, 16'd0, HI, LO, LO);
        add_step("readout_push_pop", HI, LO, LO, HI, 16'd0, HI, LO, HI);
        repeat (3) add_step("readout_pop", HI, LO, LO, HI, 16'd0, LO, LO, HI);
        // Push-none comes out as zeros
        add_step("push_none", HI, LO, LO, HI, 16'd0, HI, HI, LO);
        repeat (2) add_step("none_pop", HI, LO, LO, HI, 16'd0, LO, LO, HI);
        // Pops stay closed while filling with no readout and nothing armed
        repeat (4) add_step("fill", HI, LO, LO, LO, 16'd0, HI, LO, LO);
        add_step("full_offer", HI, LO, LO, LO, 16'd0, HI, LO, LO);
        // Back-pressure holds head and valid
        repeat (2) add_step("full_hold", HI, LO, LO, HI, 16'd0, HI, LO, LO);
        // Arm request without en is ignored
        add_step("en_low", LO, LO, HI, HI, 16'd0, HI, LO, HI);
        // Pops open once an armed computation is busy
        add_step("arm", HI, LO, HI, LO, 16'd0, HI, LO, LO);
        repeat (2) add_step("armed_pop", HI, LO, LO, LO, 16'd0, HI, LO, HI);
        repeat (5) add_step("armed_drain", HI, LO, LO, LO, 16'd0, LO, LO, HI);
        // Iteration count of three
        add_step("flush_clean", HI, HI, LO, LO, 16'd3, LO, LO, LO);
        repeat (4) add_step("iter_fill", HI, LO, LO, LO, 16'd3, HI, LO, LO);
        add_step("iter_arm", HI, LO, HI, LO, 16'd3, LO, LO, HI);
        repeat (4) add_step("iter_run", HI, LO, LO, LO, 16'd3, LO, LO, HI);
        // Host pops after finish leave the count alone
        add_step("iter_host_pop", HI, LO, LO, HI, 16'd3, LO, LO, HI);
        // Refill after finish ends the computation
        repeat (4) add_step("iter_refill", HI, LO, LO, LO, 16'd3, HI, LO, HI);
        repeat (2) add_step("iter_done", HI, LO, LO, LO, 16'd3, LO, LO, HI);
        repeat (5) add_step("iter_readout", HI, LO, LO, HI, 16'd3, LO, LO, HI);
        // Flush clears status, wins over an arm and drops a same-cycle push
        repeat (2) add_step("pre_flush", HI, LO, LO, LO, 16'd1, HI, LO, LO);
        add_step("arm_one", HI, LO, HI, LO, 16'd1, LO, LO, LO);
        add_step("pop_one", HI, LO, LO, LO, 16'd1, LO, LO, HI);
        add_step("finish_held", HI, LO, LO, LO, 16'd1, LO, LO, HI);
        add_step("flush_push", HI, HI, HI, LO, 16'd1, HI, LO, LO);
        repeat (2) add_step("after_flush", HI, LO, LO, HI, 16'd1, LO, LO, HI);
        add_step("post_flush_push", HI, LO, LO, HI, 16'd1, HI, LO, LO);
        repeat (2) add_step("post_flush_pop", HI, LO, LO, HI, 16'd1, LO, LO, HI);
    endtask

    task automatic drive_step(input int i);
        en_i           = steps[i].en;
        flush_i        = steps[i].flush;
        cmpt_en_i      = steps[i].cmpt_en;
        host_readout_i = steps[i].host;
        num_iter_i     = steps[i].num_iter;
        push_valid_i   = steps[i].push_valid;
        push_data_i    = steps[i].push_data;
        push_none_i    = steps[i].push_none;
        pop_ready_i    = steps[i].pop_ready;
    endtask

    task automatic check_step(input int i);
        string test;
        test = $sformatf("step %0d %s", i, step_name[i]);
        check_bit(test, "push_ready", steps[i].exp_push_ready, push_ready_o);
        check_bit(test, "pop_valid", steps[i].exp_pop_valid, pop_valid_o);
        // Data only defined while valid
        if (steps[i].exp_pop_valid) begin
            check_spin(test, "pop_data", steps[i].exp_pop_data, pop_data_o);
        end
        check_usage(test, steps[i].exp_usage, usage_o);
        check_bit(test, "cmpt_busy", steps[i].exp_busy, cmpt_busy_o);
        check_bit(test, "icon_finish", steps[i].exp_finish, icon_finish_o);
        check_iter(test, steps[i].exp_iter, iter_count_o);
    endtask

    initial begin
        table_built    = LO;
        rst_i          = HI;
        en_i           = LO;
        flush_i        = LO;
        cmpt_en_i      = LO;
        host_readout_i = LO;
        num_iter_i     = '0;
        push_valid_i   = LO;
        push_data_i    = SPIN_ZERO;
        push_none_i    = LO;
        pop_ready_i    = LO;
        build_table();
        table_built = HI;
        repeat (RST_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY;
        rst_i = LO;
        for (int i = 0; i < n_steps; i++) begin
            if (i > 0) begin
                @(posedge clk_i);
                #DRIVE_DELAY;
            end
            drive_step(i);
            // Sample well before the next edge
            #SAMPLE_DELAY;
            check_step(i);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

    // Twice the expected run length
    initial begin
        wait (table_built);
        #((RST_CYCLES + n_steps) * CLK_PERIOD * 2);
        $display("Timeout: the step table did not complete in time");
        stop_with_failure();
    end

endmodule

// ==== build.f ====
spin_pkg.sv
spin_stream_if.sv
spin_fifo.sv
spin_maintainer.sv
icon_tracker.sv
spin_buffer_top.sv
tb_clk_gen.sv
tb_spin_buffer.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --timing
TOP       := tb_spin_buffer
RTL_TOP   := spin_buffer_top
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TEST RESULT: PASS

.PHONY: all lint sim build clean

all: sim

# Lint the design alone, then the design with its testbench
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) \
		spin_pkg.sv spin_stream_if.sv spin_fifo.sv spin_maintainer.sv \
		icon_tracker.sv spin_buffer_top.sv
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# The run may stop on $fatal, so the log decides the result
sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
